// File: Bender.yml
package:
  name: qa_afu

sources:
  - include_dirs:
      - design
    files:
      - design/qa_pkg.sv
      - design/afu_csr.sv
      - design/status_writer.sv
      - design/block_writer.sv
      - design/write_arbiter.sv
      - design/qa_afu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/clock_gen.sv
      - bench/tb_qa_afu.sv

// File: bench/clock_gen.sv
// ==================================================
// 20 ns clock, resetb held low for the first two rising edges
// ==================================================
`timescale 1ns/1ps

module clock_gen (
   output logic clk,
   output logic resetb
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset is released on a rising edge like any other driven input
   initial begin
      resetb = 1'b0;
      repeat (2) @(posedge clk);
      resetb <= 1'b1;
   end

endmodule

// File: bench/qa_stim.txt
# Columns: cmd arg1 arg2; C addr data, F level, W cycles, S, B base count
# C/B arguments are hex, F and W are decimal; S and B queue expected Tx1 writes
W 4
C 01 00001000
C 02 00000008
B 00001000 0008
W 3
C 00 00000800
S
W 20
C 00 00000900
W 8
C 01 00002000
F 1
C 02 00000006
B 00002000 0006
W 10
F 0
W 2
F 1
W 6
F 0
W 15
C 02 00000000
B 00002000 0000
W 4

// File: bench/tb_qa_afu.sv
// ==================================================
// Runs bench/qa_stim.txt against the write path and checks every Tx1 write
// Status and block regions in the stimulus must not overlap in address
// ==================================================
`timescale 1ns/1ps
`include "qa_defines.svh"

module tb_qa_afu import qa_pkg::*; ();

   // One expected Tx1 write, done is only checked for block lines
   typedef struct packed {
      write_header_t header;
      cl_data_t      data;
      logic          done;
   } exp_write_t;

   logic       clk;
   logic       resetb;
   csr_write_t csr_write;
   logic       tx_almost_full;
   tx1_t       tx1;
   logic       block_done;

   exp_write_t status_q[$];
   exp_write_t block_q[$];
   string      stim_lines[$];
   logic       stim_loaded;
   logic       exp_done;
   logic       af_prev;
   int         overtaken;
   // Most recent DSM base written by the stimulus
   cl_addr_t   dsm_base_exp;

   clock_gen u_clock_gen (
      .clk    (clk),
      .resetb (resetb)
   );

   qa_afu_top UUT (
      .clk            (clk),
      .resetb         (resetb),
      .csr_write      (csr_write),
      .tx_almost_full (tx_almost_full),
      .tx1            (tx1),
      .block_done     (block_done)
   );

   // ==================================================
   // Expected values and checks
   // ==================================================

   // Signature in words 0 to 3 and zeros in the twelve words above
   function automatic cl_data_t status_line();
      cl_data_t d;
      d = '0;
      d[127:0] = {`QA_STATUS_SIG3, `QA_STATUS_SIG2, `QA_STATUS_SIG1, `QA_STATUS_SIG0};
      return d;
   endfunction

   // Word w of line i carries i in its upper half and w in its lower half
   function automatic cl_data_t pattern_line(int idx);
      cl_data_t d;
      for (int w = 0; w < 16; w++) begin
         d[32*w +: 32] = {idx[15:0], w[15:0]};
      end
      return d;
   endfunction

   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_header(string name, write_header_t actual, write_header_t expected);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, name, actual, expected);
         stop_run();
      end
   endtask

   task automatic check_data(string name, cl_data_t actual, cl_data_t expected);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, name, actual, expected);
         stop_run();
      end
   endtask

   task automatic check_done(string name, logic actual, logic expected);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s got %b expected %b", $time, name, actual, expected);
         stop_run();
      end
   endtask

   // ==================================================
   // Tx1 monitor
   // ==================================================

   // Sampled on the falling edge, where tx1 and block_done are settled
   always @(negedge clk) begin
      exp_write_t rec;
      if (resetb) begin
         // One write may still land in the first almost-full cycle, none after that
         if (tx1.valid && tx_almost_full && af_prev) begin
            $display("A Tx1 write appeared while almost-full was held high");
            stop_run();
         end
         if (tx1.valid) begin
            if ((status_q.size() > 0) && ((block_q.size() == 0) ||
                (tx1.header.address == status_q[0].header.address))) begin
               rec = status_q.pop_front();
            end else if (block_q.size() > 0) begin
               // At most the line already in flight may pass a pending status line
               if (status_q.size() > 0) begin
                  overtaken++;
               end
               if (overtaken > 1) begin
                  $display("Block lines overtook the pending status line");
                  stop_run();
               end
               rec = block_q.pop_front();
               check_done("block_done", block_done, rec.done);
            end else begin
               $display("Tx1 write to %h arrived with nothing expected", tx1.header.address);
               stop_run();
            end
            check_header("tx1.header", tx1.header, rec.header);
            check_data("tx1.data", tx1.data, rec.data);
         end
      end
      af_prev = tx_almost_full;
   end

   // ==================================================
   // Stimulus
   // ==================================================

   task automatic csr_pulse(logic [31:0] addr, logic [31:0] data);
      @(posedge clk);
      csr_write <= '{valid: 1'b1, addr: addr[7:0], data: data};
      @(posedge clk);
      csr_write <= '0;
   endtask

   task automatic run_line(string line);
      byte         cmd;
      int          n;
      logic [31:0] a;
      logic [31:0] b;
      exp_write_t  rec;
      cmd = line.getc(0);
      if ((line.len() == 0) || (cmd == "#") || (cmd == 8'h0a) || (cmd == " ")) begin
         return;
      end
      case (cmd)
         "C": begin
            n = $sscanf(line, "C %h %h", a, b);
            // The status line goes to the most recent DSM base
            if (a[7:0] == `QA_CSR_DSM_BASE) begin
               dsm_base_exp = b;
            end
            csr_pulse(a, b);
         end
         "F": begin
            n = $sscanf(line, "F %d", a) + 1;
            @(posedge clk);
            tx_almost_full <= a[0];
         end
         "W": begin
            n = $sscanf(line, "W %d", a) + 1;
            repeat (a) @(posedge clk);
         end
         "S": begin
            n = 2;
            rec.header = '{req_type: `QA_REQ_WRLINE, address: dsm_base_exp};
            rec.data   = status_line();
            rec.done   = 1'b0;
            status_q.push_back(rec);
            overtaken = 0;
         end
         "B": begin
            n = $sscanf(line, "B %h %h", a, b);
            for (int i = 0; i < b; i++) begin
               rec.header = '{req_type: `QA_REQ_WRLINE, address: a + i};
               rec.data   = pattern_line(i);
               rec.done   = (i == b - 1);
               block_q.push_back(rec);
            end
            exp_done = 1'b1;
         end
         default: n = 0;
      endcase
      if (n != 2) begin
         $display("Malformed stimulus line: %s", line);
         stop_run();
      end
   endtask

   // Limit scales with the stimulus length
   initial begin
      wait (stim_loaded === 1'b1);
      repeat (20 * stim_lines.size() + 200) @(posedge clk);
      $display("Watchdog expired before the stimulus finished");
      stop_run();
   end

   initial begin
      int    fd;
      int    drain;
      string line;
      csr_write      = '0;
      tx_almost_full = 1'b0;
      stim_loaded    = 1'b0;
      exp_done       = 1'b0;
      af_prev        = 1'b0;
      overtaken      = 0;
      dsm_base_exp   = '0;
      fd = $fopen("bench/qa_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open bench/qa_stim.txt");
         stop_run();
      end
      while (!$feof(fd)) begin
         if ($fgets(line, fd)) begin
            stim_lines.push_back(line);
         end
      end
      $fclose(fd);
      stim_loaded = 1'b1;
      wait (resetb === 1'b1);
      @(posedge clk);
      check_done("block_done", block_done, 1'b0);
      foreach (stim_lines[i]) begin
         run_line(stim_lines[i]);
      end
      // Give outstanding writes a bounded time to drain
      drain = 0;
      while (((status_q.size() > 0) || (block_q.size() > 0)) && (drain < 100)) begin
         @(posedge clk);
         drain++;
      end
      repeat (5) @(posedge clk);
      check_done("block_done", block_done, exp_done);
      if ((status_q.size() == 0) && (block_q.size() == 0)) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("Expected Tx1 writes never arrived");
         stop_run();
      end
   end

endmodule

// File: compile.f
+incdir+design
design/qa_pkg.sv
design/afu_csr.sv
design/status_writer.sv
design/block_writer.sv
design/write_arbiter.sv
design/qa_afu_top.sv
bench/clock_gen.sv
bench/tb_qa_afu.sv

// File: design/afu_csr.sv
// ==================================================
// Write-only register file, host reads are not supported
// Unknown addresses are dropped and the DSM base stays valid until reset
// ==================================================
`timescale 1ns/1ps
`include "qa_defines.svh"

module afu_csr import qa_pkg::*; (
   input  logic       clk,
   input  logic       resetb,
   input  csr_write_t csr_write,
   output afu_csr_t   csr,
   output logic       start
);

   // Configuration registers
   cl_addr_t  dsm_base_q;
   logic      dsm_base_valid_q;
   cl_addr_t  buf_base_q;
   line_cnt_t line_count_q;

   // ==================================================
   // Control state
   // ==================================================

   // The valid flag is sticky, and start is a one-cycle pulse after a START write
   always_ff @(posedge clk) begin
      if (!resetb) begin
         dsm_base_valid_q <= 1'b0;
         start            <= 1'b0;
      end else begin
         start <= csr_write.valid && (csr_write.addr == `QA_CSR_START);
         if (csr_write.valid && (csr_write.addr == `QA_CSR_DSM_BASE)) begin
            dsm_base_valid_q <= 1'b1;
         end
      end
   end

   // ==================================================
   // Register capture
   // ==================================================

   // The START command carries the line count in its low bits
   always_ff @(posedge clk) begin
      if (csr_write.valid) begin
         case (csr_write.addr)
            `QA_CSR_DSM_BASE: dsm_base_q <= csr_write.data;
            `QA_CSR_BUF_BASE: buf_base_q <= csr_write.data;
            `QA_CSR_START:    line_count_q <= csr_write.data[`QA_LINE_CNT_W-1:0];
            default: ;
         endcase
      end
   end

   // New values become visible the cycle after the write edge
   always_comb begin
      csr.dsm_base       = dsm_base_q;
      csr.dsm_base_valid = dsm_base_valid_q;
      csr.buf_base       = buf_base_q;
      csr.line_count     = line_count_q;
   end

   // ==================================================
   // Checks
   // ==================================================

   // Two START writes on back-to-back cycles would break this, and the host never does that
   a_start_single_cycle: assert property (
      @(posedge clk) disable iff (!resetb)
      start |=> !start
   ) else $error("start pulse lasted more than one cycle");

endmodule

// File: design/block_writer.sv
// ==================================================
// Writes line_count pattern lines from the buffer base, one request at a time
// A start that arrives during a running block is ignored
// ==================================================
`timescale 1ns/1ps
`include "qa_defines.svh"

module block_writer import qa_pkg::*; (
   input  logic         clk,
   input  logic         resetb,
   input  afu_csr_t     csr,
   input  logic         start,
   output write_req_t   block_req,
   input  write_grant_t grant,
   output logic         block_done
);

   localparam int NUM_WORDS = `QA_CL_DATA_W / 32;

   block_state_t state;
   // Base and count are latched at start so CSR writes mid-block do not disturb it
   cl_addr_t     base_q;
   line_cnt_t    count_q;
   line_cnt_t    line_idx;
   cl_data_t     pattern;

   // ==================================================
   // FSM and line index
   // ==================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state    <= BLK_IDLE;
         line_idx <= '0;
      end else begin
         case (state)
            BLK_WRITE: begin
               // Advance only on a grant, the request holds otherwise
               if (grant.block_grant) begin
                  if (line_idx == count_q - 1'b1) begin
                     state <= BLK_DONE;
                  end else begin
                     line_idx <= line_idx + 1'b1;
                  end
               end
            end
            default: begin
               // IDLE and DONE both accept a new start, a zero count finishes at once
               if (start) begin
                  line_idx <= '0;
                  state    <= (csr.line_count == '0) ? BLK_DONE : BLK_WRITE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start && (state != BLK_WRITE)) begin
         base_q  <= csr.buf_base;
         count_q <= csr.line_count;
      end
   end

   // ==================================================
   // Pattern line and request
   // ==================================================

   // Each 32-bit word holds the line index above the word number
   always_comb begin
      for (int w = 0; w < NUM_WORDS; w++) begin
         pattern[32*w +: 32] = {line_idx, 16'(w)};
      end
   end

   always_comb begin
      block_req.request         = (state == BLK_WRITE);
      block_req.header.req_type = `QA_REQ_WRLINE;
      block_req.header.address  = base_q + cl_addr_t'(line_idx);
      block_req.data            = pattern;
   end

   assign block_done = (state == BLK_DONE);

   a_grant_only_in_write: assert property (
      @(posedge clk) disable iff (!resetb)
      grant.block_grant |-> (state == BLK_WRITE)
   ) else $error("block grant outside of WRITE state");

endmodule

// File: design/qa_afu_top.sv
// ==================================================
// Host-memory write path only, with no reads, CSR readback or completions
// tx1 follows the link almost-full level, nothing is dropped
// ==================================================
`timescale 1ns/1ps

module qa_afu_top import qa_pkg::*; (
   input  logic       clk,
   input  logic       resetb,
   input  csr_write_t csr_write,
   input  logic       tx_almost_full,
   output tx1_t       tx1,
   output logic       block_done
);

   // Configuration and start command from the CSR block
   afu_csr_t     csr;
   logic         start;

   // Requests into the arbiter and grants back out
   write_req_t   status_req;
   write_req_t   block_req;
   write_grant_t grant;

   afu_csr u_afu_csr (
      .clk       (clk),
      .resetb    (resetb),
      .csr_write (csr_write),
      .csr       (csr),
      .start     (start)
   );

   status_writer u_status_writer (
      .clk        (clk),
      .resetb     (resetb),
      .csr        (csr),
      .status_req (status_req),
      .grant      (grant)
   );

   block_writer u_block_writer (
      .clk        (clk),
      .resetb     (resetb),
      .csr        (csr),
      .start      (start),
      .block_req  (block_req),
      .grant      (grant),
      .block_done (block_done)
   );

   // Status line takes priority on the shared Tx1 channel
   write_arbiter u_write_arbiter (
      .clk            (clk),
      .resetb         (resetb),
      .status_req     (status_req),
      .block_req      (block_req),
      .tx_almost_full (tx_almost_full),
      .grant          (grant),
      .tx1            (tx1)
   );

endmodule

// File: design/qa_defines.svh
// ==================================================
// Widths and codes are fixed by the host link, so nothing here is meant to be overridden
// Status signature words fill the low four words of the status line only
// ==================================================
`ifndef QA_DEFINES_SVH
`define QA_DEFINES_SVH

// ==================================================
// Link widths
// ==================================================

// Cache-line address as carried on the Tx1 header
`define QA_CL_ADDR_W 32
// One full cache line per write
`define QA_CL_DATA_W 512
// Host CSR write address and data widths
`define QA_CSR_ADDR_W 8
`define QA_CSR_DATA_W 32
// Line count carried by the start command
`define QA_LINE_CNT_W 16
// Request-type field of the write header
`define QA_REQ_TYPE_W 4

// ==================================================
// CSR map and codes
// ==================================================

`define QA_CSR_DSM_BASE 8'h00
`define QA_CSR_BUF_BASE 8'h01
`define QA_CSR_START 8'h02

// Write-line request code as understood by the link
`define QA_REQ_WRLINE 4'h2

// Signature words for status words 0 to 3
`define QA_STATUS_SIG0 32'haced0000
`define QA_STATUS_SIG1 32'haced0001
`define QA_STATUS_SIG2 32'haced0002
`define QA_STATUS_SIG3 32'haced0003

`endif

// File: design/qa_pkg.sv
// ==================================================
// Types shared by every block of the write path
// Struct layouts follow the Tx1 write channel and are not meant to change
// ==================================================
`include "qa_defines.svh"

package qa_pkg;

   // ==================================================
   // Plain vectors
   // ==================================================

   typedef logic [`QA_CL_ADDR_W-1:0] cl_addr_t;
   typedef logic [`QA_CL_DATA_W-1:0] cl_data_t;
   typedef logic [`QA_CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [`QA_CSR_DATA_W-1:0] csr_data_t;
   typedef logic [`QA_LINE_CNT_W-1:0] line_cnt_t;
   typedef logic [`QA_REQ_TYPE_W-1:0] req_type_t;

   // ==================================================
   // Structs
   // ==================================================

   // One host register write, valid for a single cycle
   typedef struct packed {
      logic      valid;
      csr_addr_t addr;
      csr_data_t data;
   } csr_write_t;

   // Configuration seen by both writers
   typedef struct packed {
      cl_addr_t  dsm_base;
      logic      dsm_base_valid;
      cl_addr_t  buf_base;
      line_cnt_t line_count;
   } afu_csr_t;

   typedef struct packed {
      req_type_t req_type;
      cl_addr_t  address;
   } write_header_t;

   // A requester holds this stable until it is granted
   typedef struct packed {
      logic          request;
      write_header_t header;
      cl_data_t      data;
   } write_req_t;

   // Grants are single-cycle pulses, at most one high
   typedef struct packed {
      logic status_grant;
      logic block_grant;
   } write_grant_t;

   typedef struct packed {
      logic          valid;
      write_header_t header;
      cl_data_t      data;
   } tx1_t;

   // ==================================================
   // State machines
   // ==================================================

   typedef enum logic {ST_IDLE, ST_DONE} status_state_t;
   typedef enum logic [1:0] {BLK_IDLE, BLK_WRITE, BLK_DONE} block_state_t;

endpackage

// File: design/status_writer.sv
// ==================================================
// Writes one signature line to the DSM base, once per reset
// Later DSM base writes do not retrigger it
// ==================================================
`timescale 1ns/1ps
`include "qa_defines.svh"

module status_writer import qa_pkg::*; (
   input  logic         clk,
   input  logic         resetb,
   input  afu_csr_t     csr,
   output write_req_t   status_req,
   input  write_grant_t grant
);

   // Signature in words 0 to 3, the upper twelve words are zero
   localparam cl_data_t STATUS_LINE = {
      {(`QA_CL_DATA_W-128){1'b0}},
      `QA_STATUS_SIG3,
      `QA_STATUS_SIG2,
      `QA_STATUS_SIG1,
      `QA_STATUS_SIG0
   };

   status_state_t state;
   status_state_t next_state;

   // ==================================================
   // FSM
   // ==================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= ST_IDLE;
      end else begin
         state <= next_state;
      end
   end

   // Once granted the writer parks in DONE until reset
   always_comb begin
      next_state = state;
      if ((state == ST_IDLE) && grant.status_grant) begin
         next_state = ST_DONE;
      end
   end

   // ==================================================
   // Tx1 request
   // ==================================================

   // The line goes to offset zero of the DSM
   always_comb begin
      status_req.request         = (state == ST_IDLE) && csr.dsm_base_valid;
      status_req.header.req_type = `QA_REQ_WRLINE;
      status_req.header.address  = csr.dsm_base;
      status_req.data            = STATUS_LINE;
   end

   // A second status grant would mean the arbiter granted a dropped request
   a_no_grant_when_done: assert property (
      @(posedge clk) disable iff (!resetb)
      !(grant.status_grant && (state == ST_DONE))
   ) else $error("status grant while status writer is done");

endmodule

// File: design/write_arbiter.sv
// ==================================================
// Fixed priority, the status writer always wins over the block writer
// No grant is given while the link is almost full
// ==================================================
`timescale 1ns/1ps

module write_arbiter import qa_pkg::*; (
   input  logic         clk,
   input  logic         resetb,
   input  write_req_t   status_req,
   input  write_req_t   block_req,
   input  logic         tx_almost_full,
   output write_grant_t grant,
   output tx1_t         tx1
);

   logic          status_grant;
   logic          block_grant;
   logic          any_grant;
   write_header_t win_header;
   cl_data_t      win_data;

   // Registered Tx1 stage
   logic          valid_q;
   write_header_t header_q;
   cl_data_t      data_q;

   // ==================================================
   // Grant logic
   // ==================================================

   // Back-pressure blocks both grants and the requests simply wait
   assign status_grant = status_req.request && !tx_almost_full;
   assign block_grant  = block_req.request && !status_req.request && !tx_almost_full;
   assign any_grant    = status_grant || block_grant;

   assign grant = '{status_grant: status_grant, block_grant: block_grant};

   // Winner select, only meaningful when a grant is given
   always_comb begin
      if (status_grant) begin
         win_header = status_req.header;
         win_data   = status_req.data;
      end else begin
         win_header = block_req.header;
         win_data   = block_req.data;
      end
   end

   // ==================================================
   // Tx1 output stage
   // ==================================================

   // A grant at one edge shows up as a Tx1 write in the following cycle
   always_ff @(posedge clk) begin
      if (!resetb) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= any_grant;
      end
   end

   always_ff @(posedge clk) begin
      if (any_grant) begin
         header_q <= win_header;
         data_q   <= win_data;
      end
   end

   assign tx1 = '{valid: valid_q, header: header_q, data: data_q};

   // A block request that is not granted keeps its request and header for the next cycle
   a_block_req_held: assert property (
      @(posedge clk) disable iff (!resetb)
      (block_req.request && !block_grant) |=>
         (block_req.request && $stable(block_req.header))
   ) else $error("block request dropped or changed before its grant");

endmodule
